// File: common/ctrl_pkg.sv
package ctrl_pkg;

    // instruction opcode, bits 27..21
    typedef enum logic [6:0] {
        OP_NOP = 7'h00,
        OP_ADD = 7'h01,
        OP_SUB = 7'h02,
        OP_AND = 7'h03,
        OP_ORR = 7'h04,
        OP_MOV = 7'h05,
        OP_CMP = 7'h06,
        OP_LDR = 7'h07,
        OP_STR = 7'h08,
        OP_B   = 7'h09
    } op_e;

    // ARM style condition field, bits 31..28
    typedef enum logic [3:0] {
        EQ = 4'h0,
        NE = 4'h1,
        CS = 4'h2,
        CC = 4'h3,
        MI = 4'h4,
        PL = 4'h5,
        VS = 4'h6,
        VC = 4'h7,
        HI = 4'h8,
        LS = 4'h9,
        GE = 4'ha,
        LT = 4'hb,
        GT = 4'hc,
        LE = 4'hd,
        AL = 4'he
    } cond_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_ORR  = 3'd3,
        ALU_PASS = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_INC    = 2'd0,
        PC_RESET  = 2'd1,
        PC_BRANCH = 2'd2
    } pc_sel_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1
    } fwd_sel_e;

    // instruction field positions
    localparam int COND_HI       = 31;
    localparam int COND_LO       = 28;
    localparam int OP_HI         = 27;
    localparam int OP_LO         = 21;
    localparam int RN_HI         = 19;
    localparam int RN_LO         = 16;
    localparam int RD_HI         = 15;
    localparam int RD_LO         = 12;
    localparam int RS_HI         = 11;
    localparam int RS_LO         = 8;
    localparam int IMM5_HI       = 11;
    localparam int IMM5_LO       = 7;
    localparam int SHIFT_HI      = 6;
    localparam int SHIFT_LO      = 5;
    localparam int RM_HI         = 3;
    localparam int RM_LO         = 0;
    localparam int IMM12_HI      = 11;
    localparam int IMM12_LO      = 0;
    localparam int BOFF_HI       = 20;
    localparam int BOFF_LO       = 0;
    localparam int SHIFT_REG_BIT = 4;
    localparam int PRE_IDX_BIT   = 20;

    // status flags N Z C V
    localparam int FLAG_N = 31;
    localparam int FLAG_V = 28;

    // instruction word with the branch reference it was fetched under
    typedef struct packed {
        logic [31:0] instr;
        logic        tag;
    } stage_t;

    typedef struct packed {
        op_e        opcode;
        logic [3:0] rn;
        logic [3:0] rs;
        logic [3:0] rm;
        logic [4:0] imm5;
        fwd_sel_e   sel_a_in;
        fwd_sel_e   sel_b_in;
        fwd_sel_e   sel_shift_in;
        logic       sel_shift;
        logic       en_a;
        logic       en_b;
        logic       en_s;
    } ex_ctrl_t;

    typedef struct packed {
        op_e         opcode;
        logic [3:0]  rd;
        logic [1:0]  shift_op;
        logic [11:0] imm12;
        logic [31:0] imm_branch;
        pc_sel_e     sel_pc;
        logic        load_pc;
        logic        sel_branch_imm;
        logic        sel_a;
        logic        sel_b;
        alu_op_e     alu_op;
        logic        sel_pre_indexed;
        logic        en_status;
        logic        w_en1;
        logic        mem_w_en;
    } mem_ctrl_t;

endpackage

// File: hdl/fetch_tracker.sv
`timescale 1ns/1ps

module fetch_tracker (
    input  logic clk,
    input  logic rst_n,
    input  logic branch_ref,
    output logic fetch_tag
);

    // reference seen by the fetch stage and by the fetch-wait stage
    logic fetch_ref;
    logic wait_ref;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_ref <= 1'b0;
            wait_ref  <= 1'b0;
        end else begin
            fetch_ref <= branch_ref;
            wait_ref  <= fetch_ref;
        end
    end

    // word on instr_in was requested under the fetch stage reference
    assign fetch_tag = fetch_ref;

    tag_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(fetch_tag)
    ) else $error("fetch tag unknown after reset");

    // two shadow slots follow a taken branch, so flips are at least three cycles apart
    flip_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fetch_ref != wait_ref) |=> (fetch_ref == wait_ref) [*2]
    ) else $error("branch reference flipped inside a branch shadow");

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        instr_in,
    input  logic               fetch_tag,
    input  logic               stall,
    input  logic [3:0]         mem_rd,
    input  logic               mem_w_en1,
    output ctrl_pkg::stage_t   ex_out,
    output ctrl_pkg::ex_ctrl_t ex_ctrl
);
    import ctrl_pkg::*;

    stage_t     ex_q;
    op_e        op;
    logic [3:0] rn;
    logic [3:0] rs;
    logic [3:0] rm;
    logic       reg_shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else if (!stall) begin
            ex_q.instr <= instr_in;
            ex_q.tag   <= fetch_tag;
        end
    end

    // held stage sends a bubble on
    assign ex_out = stall ? '0 : ex_q;

    assign op        = op_e'(ex_q.instr[OP_HI:OP_LO]);
    assign rn        = ex_q.instr[RN_HI:RN_LO];
    assign rs        = ex_q.instr[RS_HI:RS_LO];
    assign rm        = ex_q.instr[RM_HI:RM_LO];
    assign reg_shift = ex_q.instr[SHIFT_REG_BIT];

    always_comb begin
        ex_ctrl        = '0;
        ex_ctrl.opcode = op;
        ex_ctrl.rn     = rn;
        ex_ctrl.rs     = rs;
        ex_ctrl.rm     = rm;
        ex_ctrl.imm5   = ex_q.instr[IMM5_HI:IMM5_LO];

        // result still in the memory stage, take it from there
        ex_ctrl.sel_a_in     = (mem_w_en1 && rn == mem_rd) ? FWD_MEM : FWD_REG;
        ex_ctrl.sel_b_in     = (mem_w_en1 && rm == mem_rd) ? FWD_MEM : FWD_REG;
        ex_ctrl.sel_shift_in = (mem_w_en1 && rs == mem_rd) ? FWD_MEM : FWD_REG;
        // shift amount from rs instead of imm5
        ex_ctrl.sel_shift    = reg_shift;

        if (!stall) begin
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_CMP: begin
                    ex_ctrl.en_a = 1'b1;
                    ex_ctrl.en_b = 1'b1;
                    ex_ctrl.en_s = reg_shift;
                end
                OP_MOV: begin
                    ex_ctrl.en_b = 1'b1;
                    ex_ctrl.en_s = reg_shift;
                end
                // base register only
                OP_LDR: begin
                    ex_ctrl.en_a = 1'b1;
                end
                OP_STR: begin
                    ex_ctrl.en_a = 1'b1;
                    ex_ctrl.en_b = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> $stable(ex_q)
    ) else $error("execute register changed while stalled");

endmodule

// File: memory/memory_unit.sv
`timescale 1ns/1ps

module memory_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  ctrl_pkg::stage_t    ex_in,
    input  logic                stall,
    input  logic [31:0]         status_reg,
    input  logic                startup_load,
    output ctrl_pkg::mem_ctrl_t mem_ctrl,
    output ctrl_pkg::stage_t    mem_out,
    output logic                branch_ref
);
    import ctrl_pkg::*;

    stage_t mem_q;
    logic   ref_q;
    op_e    op;
    cond_e  cond;
    logic   flag_n;
    logic   flag_z;
    logic   flag_c;
    logic   flag_v;
    logic   cond_pass;
    logic   live;
    logic   go;
    logic   take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_q <= '0;
        end else if (!stall) begin
            mem_q <= ex_in;
        end
    end

    // flips once for every taken branch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_q <= 1'b0;
        end else begin
            ref_q <= ref_q ^ take;
        end
    end

    assign op   = op_e'(mem_q.instr[OP_HI:OP_LO]);
    assign cond = cond_e'(mem_q.instr[COND_HI:COND_LO]);
    assign {flag_n, flag_z, flag_c, flag_v} = status_reg[FLAG_N:FLAG_V];

    always_comb begin
        case (cond)
            EQ:      cond_pass = flag_z;
            NE:      cond_pass = !flag_z;
            CS:      cond_pass = flag_c;
            CC:      cond_pass = !flag_c;
            MI:      cond_pass = flag_n;
            PL:      cond_pass = !flag_n;
            VS:      cond_pass = flag_v;
            VC:      cond_pass = !flag_v;
            HI:      cond_pass = flag_c && !flag_z;
            LS:      cond_pass = !flag_c || flag_z;
            GE:      cond_pass = (flag_n == flag_v);
            LT:      cond_pass = (flag_n != flag_v);
            GT:      cond_pass = !flag_z && (flag_n == flag_v);
            LE:      cond_pass = flag_z || (flag_n != flag_v);
            AL:      cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    // stale tag means it was fetched in the shadow of a taken branch
    assign live = !stall && (mem_q.tag == ref_q);
    assign go   = live && cond_pass;
    assign take = go && (op == OP_B);

    // the reference the next fetch will run under
    assign branch_ref = ref_q ^ take;

    always_comb begin
        mem_ctrl            = '0;
        mem_ctrl.opcode     = op;
        mem_ctrl.rd         = mem_q.instr[RD_HI:RD_LO];
        mem_ctrl.shift_op   = mem_q.instr[SHIFT_HI:SHIFT_LO];
        mem_ctrl.imm12      = mem_q.instr[IMM12_HI:IMM12_LO];
        mem_ctrl.imm_branch = {{(31 - BOFF_HI){mem_q.instr[BOFF_HI]}},
                               mem_q.instr[BOFF_HI:BOFF_LO]};
        mem_ctrl.sel_pc     = PC_INC;
        mem_ctrl.alu_op     = ALU_PASS;

        case (op)
            OP_ADD: begin
                mem_ctrl.alu_op = ALU_ADD;
                mem_ctrl.w_en1  = go;
            end
            OP_SUB: begin
                mem_ctrl.alu_op = ALU_SUB;
                mem_ctrl.w_en1  = go;
            end
            OP_AND: begin
                mem_ctrl.alu_op = ALU_AND;
                mem_ctrl.w_en1  = go;
            end
            OP_ORR: begin
                mem_ctrl.alu_op = ALU_ORR;
                mem_ctrl.w_en1  = go;
            end
            OP_MOV: begin
                mem_ctrl.w_en1 = go;
            end
            OP_CMP: begin
                mem_ctrl.alu_op    = ALU_SUB;
                mem_ctrl.en_status = go;
            end
            // address is base plus imm12
            OP_LDR, OP_STR: begin
                mem_ctrl.alu_op          = ALU_ADD;
                mem_ctrl.sel_b           = 1'b1;
                mem_ctrl.sel_pre_indexed = mem_q.instr[PRE_IDX_BIT];
                mem_ctrl.mem_w_en        = go && (op == OP_STR);
            end
            // target is pc plus the branch offset
            OP_B: begin
                mem_ctrl.alu_op         = ALU_ADD;
                mem_ctrl.sel_a          = 1'b1;
                mem_ctrl.sel_branch_imm = 1'b1;
            end
            default: begin
            end
        endcase

        if (startup_load) begin
            mem_ctrl.sel_pc  = PC_RESET;
            mem_ctrl.load_pc = 1'b1;
        end else if (take) begin
            mem_ctrl.sel_pc  = PC_BRANCH;
            mem_ctrl.load_pc = 1'b1;
        end
    end

    // squashed or failed instructions leave as a nop
    always_comb begin
        mem_out = mem_q;
        if (!go) begin
            mem_out.instr[OP_HI:OP_LO] = OP_NOP;
        end
    end

    one_write_port: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_ctrl.w_en1 && mem_ctrl.mem_w_en)
    ) else $error("register write and memory write in the same cycle");

endmodule

// File: hdl/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  ctrl_pkg::stage_t mem_in,
    input  logic [1:0]       stall,
    output logic             w_en_ldr
);
    import ctrl_pkg::*;

    op_e  mw_op;
    logic mw_valid;
    logic mw_live;
    op_e  wb_op;
    logic wb_valid;

    always_ff @(posedge clk) begin
        if (!stall[0]) begin
            mw_op <= op_e'(mem_in.instr[OP_HI:OP_LO]);
        end
        if (!stall[1]) begin
            wb_op <= mw_op;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mw_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            // memory stage already turned squashed and failed words into nops
            if (!stall[0]) begin
                mw_valid <= (mem_in.instr[OP_HI:OP_LO] != OP_NOP);
            end
            if (!stall[1]) begin
                wb_valid <= mw_live;
            end
        end
    end

    // a held memory-wait stage passes a bubble
    assign mw_live  = mw_valid && !stall[0];
    assign w_en_ldr = wb_valid && !stall[1] && (wb_op == OP_LDR);

endmodule

// File: hdl/controller.sv
`timescale 1ns/1ps

module controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         instr_in,
    input  logic [31:0]         status_reg,
    output ctrl_pkg::ex_ctrl_t  ex_ctrl,
    output ctrl_pkg::mem_ctrl_t mem_ctrl,
    output logic                w_en_ldr
);
    import ctrl_pkg::*;

    typedef enum logic [2:0] {
        S_LOAD_PC_START = 3'd0,
        S_FETCH         = 3'd1,
        S_FETCH_WAIT    = 3'd2,
        S_EXECUTE       = 3'd3,
        S_MEMORY        = 3'd4,
        S_MEMORY_WAIT   = 3'd5,
        S_WRITE_BACK    = 3'd6,
        S_RUN           = 3'd7
    } state_e;

    state_e state;

    // stall bits: execute, memory, memory-wait, writeback
    logic [3:0] stall;
    logic       startup_load;
    logic       branch_ref;
    logic       fetch_tag;
    stage_t     ex_stage;
    stage_t     mem_stage;

    // pipeline fill, one stage released per state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_LOAD_PC_START;
        end else begin
            case (state)
                S_LOAD_PC_START: state <= S_FETCH;
                S_FETCH:         state <= S_FETCH_WAIT;
                S_FETCH_WAIT:    state <= S_EXECUTE;
                S_EXECUTE:       state <= S_MEMORY;
                S_MEMORY:        state <= S_MEMORY_WAIT;
                S_MEMORY_WAIT:   state <= S_WRITE_BACK;
                default:         state <= S_RUN;
            endcase
        end
    end

    always_comb begin
        case (state)
            S_EXECUTE:              stall = 4'b1110;
            S_MEMORY:               stall = 4'b1100;
            S_MEMORY_WAIT:          stall = 4'b1000;
            S_WRITE_BACK, S_RUN:    stall = 4'b0000;
            default:                stall = 4'b1111;
        endcase
    end

    assign startup_load = (state == S_LOAD_PC_START);

    fetch_tracker u_fetch_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .branch_ref (branch_ref),
        .fetch_tag  (fetch_tag)
    );

    execute_unit u_execute_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_in  (instr_in),
        .fetch_tag (fetch_tag),
        .stall     (stall[0]),
        .mem_rd    (mem_ctrl.rd),
        .mem_w_en1 (mem_ctrl.w_en1),
        .ex_out    (ex_stage),
        .ex_ctrl   (ex_ctrl)
    );

    memory_unit u_memory_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_in        (ex_stage),
        .stall        (stall[1]),
        .status_reg   (status_reg),
        .startup_load (startup_load),
        .mem_ctrl     (mem_ctrl),
        .mem_out      (mem_stage),
        .branch_ref   (branch_ref)
    );

    writeback_unit u_writeback_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_in   (mem_stage),
        .stall    (stall[3:2]),
        .w_en_ldr (w_en_ldr)
    );

    // the two slots behind a taken branch neither write nor redirect the pc
    shadow_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_ctrl.load_pc && mem_ctrl.sel_pc == PC_BRANCH) |=>
            (!(mem_ctrl.load_pc || mem_ctrl.w_en1 || mem_ctrl.mem_w_en
               || mem_ctrl.en_status)) [*2]
    ) else $error("write or pc load inside a branch shadow");

endmodule

// File: testbench/controller_tb.sv
`timescale 1ns/1ps

module controller_tb;
    import ctrl_pkg::*;

    localparam int NUM_INSTR = 400;
    // nop words at the end so the last real words leave the pipeline
    localparam int DRAIN     = 4;
    localparam int PERIOD    = 100;
    localparam int TIMEOUT   = (NUM_INSTR + DRAIN + 2 + 20) * PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr_in;
    logic [31:0] status_reg;
    ex_ctrl_t    ex_ctrl;
    mem_ctrl_t   mem_ctrl;
    logic        w_en_ldr;

    // expected values for the half cycle up to the next rising edge
    logic        check_on;
    logic [31:0] exp_ex_word;
    logic [31:0] exp_mem_word;
    logic        exp_w_en1;
    logic        exp_mem_w_en;
    logic        exp_en_status;
    logic        exp_load_pc;
    pc_sel_e     exp_sel_pc;
    logic        exp_fwd_a;
    logic        exp_fwd_b;
    logic        exp_w_en_ldr;

    // every driven word, and whether a live passing load sat in the memory stage
    logic [31:0] word_hist[$];
    logic        ldr_hist[$];
    int          shadow;
    int          errors;
    int          branches;
    int          squashed;
    int          loads;

    controller dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_in   (instr_in),
        .status_reg (status_reg),
        .ex_ctrl    (ex_ctrl),
        .mem_ctrl   (mem_ctrl),
        .w_en_ldr   (w_en_ldr)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic log_mismatch(input string msg);
        errors = errors + 1;
        $display("Fail %0t ns: %s", $time, msg);
    endtask

    // condition rules on the flags N Z C V
    function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] nzcv);
        logic n;
        logic z;
        logic c;
        logic v;
        logic res;
        n = nzcv[3];
        z = nzcv[2];
        c = nzcv[1];
        v = nzcv[0];
        case (cond)
            4'h0:    res = z;
            4'h1:    res = !z;
            4'h2:    res = c;
            4'h3:    res = !c;
            4'h4:    res = n;
            4'h5:    res = !n;
            4'h6:    res = v;
            4'h7:    res = !v;
            4'h8:    res = c && !z;
            4'h9:    res = !c || z;
            4'ha:    res = (n == v);
            4'hb:    res = (n != v);
            4'hc:    res = !z && (n == v);
            4'hd:    res = z || (n != v);
            4'he:    res = 1'b1;
            default: res = 1'b0;
        endcase
        return res;
    endfunction

    function automatic logic writes_reg(input logic [6:0] op);
        return op == OP_ADD || op == OP_SUB || op == OP_AND || op == OP_ORR || op == OP_MOV;
    endfunction

    // few registers so that forwarding hits often
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w        = $urandom;
        w[27:21] = 7'($urandom % 10);
        w[19:16] = 4'($urandom % 4);
        w[15:12] = 4'($urandom % 4);
        w[3:0]   = 4'($urandom % 4);
        if ($urandom % 2 == 0) begin
            w[31:28] = 4'he;
        end
        return w;
    endfunction

    task automatic update_expected(input int j);
        logic [31:0] mem_word;
        logic [6:0]  mem_op;
        logic        live;
        logic        go;
        logic        take;
        // first word taken in is the one driven in the fourth cycle after reset
        exp_ex_word   = (j >= 4) ? word_hist[j - 1] : 32'h0;
        mem_word      = (j >= 5) ? word_hist[j - 2] : 32'h0;
        exp_mem_word  = mem_word;
        mem_op        = mem_word[27:21];
        live          = (j >= 4) && (shadow == 0);
        go            = live && cond_holds(mem_word[31:28], status_reg[31:28]);
        take          = go && (mem_op == OP_B);
        exp_w_en1     = go && writes_reg(mem_op);
        exp_mem_w_en  = go && (mem_op == OP_STR);
        exp_en_status = go && (mem_op == OP_CMP);
        exp_load_pc   = (j == 0) || take;
        exp_sel_pc    = (j == 0) ? PC_RESET : (take ? PC_BRANCH : PC_INC);
        exp_fwd_a     = exp_w_en1 && (exp_ex_word[19:16] == mem_word[15:12]);
        exp_fwd_b     = exp_w_en1 && (exp_ex_word[3:0] == mem_word[15:12]);
        ldr_hist.push_back(go && (mem_op == OP_LDR));
        exp_w_en_ldr  = (j >= 2) ? ldr_hist[j - 2] : 1'b0;
        if (go && mem_op == OP_LDR) begin
            loads = loads + 1;
        end
        // two words behind a taken branch are dropped
        if (shadow > 0) begin
            shadow   = shadow - 1;
            squashed = squashed + 1;
        end
        if (take) begin
            shadow   = 2;
            branches = branches + 1;
        end
    endtask

    ex_fields: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        ex_ctrl.opcode == exp_ex_word[27:21] && ex_ctrl.rn == exp_ex_word[19:16]
        && ex_ctrl.rs == exp_ex_word[11:8] && ex_ctrl.rm == exp_ex_word[3:0]
        && ex_ctrl.imm5 == exp_ex_word[11:7])
        else log_mismatch("ex_ctrl fields differ from the word driven one cycle back");

    mem_fields: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        mem_ctrl.opcode == exp_mem_word[27:21] && mem_ctrl.rd == exp_mem_word[15:12]
        && mem_ctrl.imm12 == exp_mem_word[11:0] && mem_ctrl.shift_op == exp_mem_word[6:5])
        else log_mismatch("mem_ctrl fields differ from the word driven two cycles back");

    reg_write: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        mem_ctrl.w_en1 == exp_w_en1)
        else log_mismatch("wrong w_en1");

    mem_write: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        mem_ctrl.mem_w_en == exp_mem_w_en)
        else log_mismatch("wrong mem_w_en");

    status_write: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        mem_ctrl.en_status == exp_en_status)
        else log_mismatch("wrong en_status");

    pc_control: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        mem_ctrl.load_pc == exp_load_pc && mem_ctrl.sel_pc == exp_sel_pc)
        else log_mismatch("wrong load_pc or sel_pc");

    forwarding: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        (ex_ctrl.sel_a_in == FWD_MEM) == exp_fwd_a && (ex_ctrl.sel_b_in == FWD_MEM) == exp_fwd_b)
        else log_mismatch("wrong forwarding select");

    load_write: assert property (@(posedge clk) disable iff (!rst_n || !check_on)
        w_en_ldr == exp_w_en_ldr)
        else log_mismatch("wrong w_en_ldr");

    initial begin
        void'($urandom(10068));
        rst_n         = 1'b0;
        instr_in      = 32'h0;
        status_reg    = 32'h0;
        check_on      = 1'b0;
        exp_ex_word   = 32'h0;
        exp_mem_word  = 32'h0;
        exp_w_en1     = 1'b0;
        exp_mem_w_en  = 1'b0;
        exp_en_status = 1'b0;
        exp_load_pc   = 1'b0;
        exp_sel_pc    = PC_INC;
        exp_fwd_a     = 1'b0;
        exp_fwd_b     = 1'b0;
        exp_w_en_ldr  = 1'b0;
        shadow        = 0;
        errors        = 0;
        branches      = 0;
        squashed      = 0;
        loads         = 0;
        repeat (2) @(posedge clk);
        for (int j = 0; j < NUM_INSTR + DRAIN; j++) begin
            @(negedge clk);
            rst_n      = 1'b1;
            instr_in   = (j < NUM_INSTR) ? random_word() : 32'h0;
            status_reg = $urandom;
            word_hist.push_back(instr_in);
            update_expected(j);
            check_on   = 1'b1;
        end
        @(negedge clk);
        $display("cycles %0d, branches %0d, squashed %0d, loads %0d, errors %0d",
                 NUM_INSTR + DRAIN, branches, squashed, loads, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: sources.f
common/ctrl_pkg.sv
hdl/fetch_tracker.sv
execute/execute_unit.sv
memory/memory_unit.sv
hdl/writeback_unit.sv
hdl/controller.sv
testbench/controller_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module controller_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vcontroller_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    echo "testbench reported failure"
    exit 1
fi

exit 0
